/* include/rv32i_cfg.svh */
// Core configuration macros
// Data width, register count, data memory depth, reset PC

`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// Data and address width
`define RV_XLEN        32

// Architectural registers, x0 included
`define RV_REG_COUNT   32

// Data memory depth in words
`define RV_DMEM_WORDS  64

// First fetch address after reset
`define RV_RESET_PC    32'h0000_0000

`endif

/* rtl/rv32i_core.sv */
// RV32I five-stage pipeline core
// PC, struct pipeline registers, stage wiring, write-back mux and strobe

`timescale 1ns/100ps

`include "rv32i_cfg.svh"

module rv32i_core import rv32i_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    output word_t     o_imem_addr,
    input  word_t     i_imem_data,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data
);

    // Fetch
    word_t     pc_q;

    // Pipeline registers
    if_id_t    if_id_q;
    id_ex_t    id_ex_q;
    ex_mem_t   ex_mem_q;
    mem_wb_t   mem_wb_q;

    // Decode
    ctrl_t     id_ctrl;
    word_t     id_imm;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    word_t     id_rs1_data;
    word_t     id_rs2_data;

    // Execute and hazards
    ex_mem_t   ex_result;
    logic      redirect;
    word_t     target;
    logic      stall;
    logic      flush;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    // Memory and write-back
    word_t     dmem_rdata;
    word_t     mem_fwd;
    word_t     wb_data;

    // Result select shared by the MEM forward path and write-back
    function automatic word_t result_mux(wb_sel_e sel, word_t alu, word_t mem, word_t pc4,
                                         word_t imm);
        case (sel)
            WB_MEM:  return mem;
            WB_PC4:  return pc4;
            WB_IMM:  return imm;
            default: return alu;
        endcase
    endfunction

    // ==============================
    // Fetch
    // ==============================
    assign o_imem_addr = pc_q;

    // Redirect beats stall, stall holds
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q <= `RV_RESET_PC;
        end else if (flush) begin
            pc_q <= target;
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // All-zero instruction decodes as a bubble
    always_ff @(posedge i_clk) begin
        if (i_reset || flush) begin
            if_id_q <= '0;
        end else if (!stall) begin
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= i_imem_data;
        end
    end

    // ==============================
    // Decode
    // ==============================
    rv32i_decoder u_decoder (
        .i_instr (if_id_q.instr),
        .o_ctrl  (id_ctrl),
        .o_imm   (id_imm),
        .o_rs1   (id_rs1),
        .o_rs2   (id_rs2),
        .o_rd    (id_rd)
    );

    rv32i_regfile u_regfile (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_we     (mem_wb_q.reg_write),
        .i_waddr  (mem_wb_q.rd),
        .i_wdata  (wb_data),
        .i_raddr1 (id_rs1),
        .i_raddr2 (id_rs2),
        .o_rdata1 (id_rs1_data),
        .o_rdata2 (id_rs2_data)
    );

    rv32i_hazard_unit u_hazard (
        .i_id_rs1        (id_rs1),
        .i_id_rs2        (id_rs2),
        .i_id_ex         (id_ex_q),
        .i_mem_rd        (ex_mem_q.rd),
        .i_wb_rd         (mem_wb_q.rd),
        .i_mem_reg_write (ex_mem_q.reg_write),
        .i_wb_reg_write  (mem_wb_q.reg_write),
        .i_redirect      (redirect),
        .o_stall         (stall),
        .o_flush         (flush),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    // Bubble on reset, redirect or load-use
    always_ff @(posedge i_clk) begin
        if (i_reset || flush || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q.pc       <= if_id_q.pc;
            id_ex_q.rs1_data <= id_rs1_data;
            id_ex_q.rs2_data <= id_rs2_data;
            id_ex_q.imm      <= id_imm;
            id_ex_q.rs1      <= id_rs1;
            id_ex_q.rs2      <= id_rs2;
            id_ex_q.rd       <= id_rd;
            id_ex_q.ctrl     <= id_ctrl;
        end
    end

    // ==============================
    // Execute
    // ==============================
    rv32i_execute u_execute (
        .i_id_ex    (id_ex_q),
        .i_fwd_a    (fwd_a),
        .i_fwd_b    (fwd_b),
        .i_mem_fwd  (mem_fwd),
        .i_wb_fwd   (wb_data),
        .o_ex_mem   (ex_result),
        .o_redirect (redirect),
        .o_target   (target)
    );

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_result;
        end
    end

    // ==============================
    // Memory
    // ==============================
    rv32i_data_mem u_data_mem (
        .i_clk   (i_clk),
        .i_we    (ex_mem_q.mem_write),
        .i_addr  (ex_mem_q.alu_result),
        .i_wdata (ex_mem_q.store_data),
        .o_rdata (dmem_rdata)
    );

    // Load results reach execute only after the load-use stall
    assign mem_fwd = result_mux(ex_mem_q.wb_sel, ex_mem_q.alu_result, dmem_rdata,
                                ex_mem_q.pc4, ex_mem_q.imm);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.alu_result <= ex_mem_q.alu_result;
            mem_wb_q.load_data  <= dmem_rdata;
            mem_wb_q.pc4        <= ex_mem_q.pc4;
            mem_wb_q.imm        <= ex_mem_q.imm;
            mem_wb_q.rd         <= ex_mem_q.rd;
            mem_wb_q.reg_write  <= ex_mem_q.reg_write;
            mem_wb_q.wb_sel     <= ex_mem_q.wb_sel;
        end
    end

    // ==============================
    // Write-back
    // ==============================
    assign wb_data = result_mux(mem_wb_q.wb_sel, mem_wb_q.alu_result, mem_wb_q.load_data,
                                mem_wb_q.pc4, mem_wb_q.imm);

    // reg_write is already clear for x0 destinations
    assign o_wb_valid = mem_wb_q.reg_write;
    assign o_wb_rd    = mem_wb_q.rd;
    assign o_wb_data  = wb_data;

endmodule

/* rtl/rv32i_data_mem.sv */
// Word-wide data memory
// Synchronous write, combinational read

`timescale 1ns/100ps

module rv32i_data_mem import rv32i_pkg::*; (
    input  logic  i_clk,
    input  logic  i_we,
    input  word_t i_addr,
    input  word_t i_wdata,
    output word_t o_rdata
);

    word_t                  mem [DMEM_WORDS];
    logic [DMEM_AW-1:0]     word_idx;

    // Byte address to word index, upper bits wrap
    assign word_idx = i_addr[DMEM_AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[word_idx] <= i_wdata;
        end
    end

    // Read is valid in the same cycle as the address
    assign o_rdata = mem[word_idx];

endmodule

/* rtl/rv32i_decoder.sv */
// Instruction decoder
// Control fields plus I/S/B/U/J immediate generation

`timescale 1ns/100ps

module rv32i_decoder import rv32i_pkg::*; (
    input  word_t     i_instr,
    output ctrl_t     o_ctrl,
    output word_t     o_imm,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output reg_addr_t o_rd
);

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = i_instr[6:0];
    assign funct3   = i_instr[14:12];
    assign funct7_5 = i_instr[30];

    assign o_rd  = i_instr[11:7];
    assign o_rs1 = i_instr[19:15];
    assign o_rs2 = i_instr[24:20];

    // funct3 to ALU op, alt selects SUB / SRA
    function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        // Bubble unless a known encoding matches
        o_ctrl = '0;
        o_imm  = '0;
        case (opcode)
            OPC_OP: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = alu_decode(funct3, funct7_5);
            end
            OPC_OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                // Bit 30 is an immediate bit except on right shifts
                o_ctrl.alu_op      = alu_decode(funct3, funct7_5 && funct3 == 3'b101);
                o_imm              = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            OPC_LUI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = WB_IMM;
                o_imm            = {i_instr[31:12], 12'b0};
            end
            OPC_LOAD: if (funct3 == 3'b010) begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.wb_sel      = WB_MEM;
                o_ctrl.alu_src_imm = 1'b1;
                o_imm              = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            OPC_STORE: if (funct3 == 3'b010) begin
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_imm              = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            OPC_BRANCH: if (funct3[2:1] == 2'b00) begin
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = funct3[0];
                o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.jal       = 1'b1;
                o_ctrl.wb_sel    = WB_PC4;
                o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                         i_instr[20], i_instr[30:21], 1'b0};
            end
            default: ;
        endcase
        // x0 destination never counts as a write
        if (o_rd == '0) begin
            o_ctrl.reg_write = 1'b0;
        end
    end

endmodule

/* rtl/rv32i_execute.sv */
// Execute stage
// Operand forwarding, ALU, BEQ/BNE compare, branch and JAL target

`timescale 1ns/100ps

module rv32i_execute import rv32i_pkg::*; (
    input  id_ex_t   i_id_ex,
    input  fwd_sel_e i_fwd_a,
    input  fwd_sel_e i_fwd_b,
    input  word_t    i_mem_fwd,
    input  word_t    i_wb_fwd,
    output ex_mem_t  o_ex_mem,
    output logic     o_redirect,
    output word_t    o_target
);

    word_t opnd_a;
    word_t opnd_b_reg;
    word_t opnd_b;
    word_t alu_out;
    logic  equal;
    logic  taken;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ==============================
    // Operands
    // ==============================
    assign opnd_a     = fwd_mux(i_fwd_a, i_id_ex.rs1_data, i_mem_fwd, i_wb_fwd);
    assign opnd_b_reg = fwd_mux(i_fwd_b, i_id_ex.rs2_data, i_mem_fwd, i_wb_fwd);
    assign opnd_b     = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : opnd_b_reg;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_SUB:  alu_out = opnd_a - opnd_b;
            ALU_AND:  alu_out = opnd_a & opnd_b;
            ALU_OR:   alu_out = opnd_a | opnd_b;
            ALU_XOR:  alu_out = opnd_a ^ opnd_b;
            ALU_SLT:  alu_out = word_t'($signed(opnd_a) < $signed(opnd_b));
            ALU_SLTU: alu_out = word_t'(opnd_a < opnd_b);
            // Shift amount from the low five bits only
            ALU_SLL:  alu_out = opnd_a << opnd_b[4:0];
            ALU_SRL:  alu_out = opnd_a >> opnd_b[4:0];
            ALU_SRA:  alu_out = word_t'($signed(opnd_a) >>> opnd_b[4:0]);
            default:  alu_out = opnd_a + opnd_b;
        endcase
    end

    // ==============================
    // Branch and jump
    // ==============================
    // Compare uses rs2, never the immediate
    assign equal      = opnd_a == opnd_b_reg;
    assign taken      = i_id_ex.ctrl.branch && (equal ^ i_id_ex.ctrl.branch_ne);
    assign o_redirect = taken || i_id_ex.ctrl.jal;
    // Same adder for B and J immediates
    assign o_target   = i_id_ex.pc + i_id_ex.imm;

    always_comb begin
        o_ex_mem.alu_result = alu_out;
        // Forwarded rs2 for SW
        o_ex_mem.store_data = opnd_b_reg;
        // Link value for JAL
        o_ex_mem.pc4        = i_id_ex.pc + 32'd4;
        o_ex_mem.imm        = i_id_ex.imm;
        o_ex_mem.rd         = i_id_ex.rd;
        o_ex_mem.reg_write  = i_id_ex.ctrl.reg_write;
        o_ex_mem.mem_read   = i_id_ex.ctrl.mem_read;
        o_ex_mem.mem_write  = i_id_ex.ctrl.mem_write;
        o_ex_mem.wb_sel     = i_id_ex.ctrl.wb_sel;
    end

endmodule

/* rtl/rv32i_hazard_unit.sv */
// Hazard unit
// Load-use stall, redirect flush, execute operand forwarding selects

`timescale 1ns/100ps

module rv32i_hazard_unit import rv32i_pkg::*; (
    input  reg_addr_t i_id_rs1,
    input  reg_addr_t i_id_rs2,
    input  id_ex_t    i_id_ex,
    input  reg_addr_t i_mem_rd,
    input  reg_addr_t i_wb_rd,
    input  logic      i_mem_reg_write,
    input  logic      i_wb_reg_write,
    input  logic      i_redirect,
    output logic      o_stall,
    output logic      o_flush,
    output fwd_sel_e  o_fwd_a,
    output fwd_sel_e  o_fwd_b
);

    // Newest producer wins, MEM before WB
    function automatic fwd_sel_e pick_src(reg_addr_t src, reg_addr_t mem_rd, logic mem_we,
                                          reg_addr_t wb_rd, logic wb_we);
        if (mem_we && mem_rd != '0 && mem_rd == src) begin
            return FWD_MEM;
        end else if (wb_we && wb_rd != '0 && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    // Load data only exists after memory, so decode waits one cycle
    assign o_stall = i_id_ex.ctrl.mem_read && i_id_ex.rd != '0 &&
                     (i_id_ex.rd == i_id_rs1 || i_id_ex.rd == i_id_rs2);

    // Kill the two younger instructions
    assign o_flush = i_redirect;

    assign o_fwd_a = pick_src(i_id_ex.rs1, i_mem_rd, i_mem_reg_write,
                              i_wb_rd, i_wb_reg_write);
    assign o_fwd_b = pick_src(i_id_ex.rs2, i_mem_rd, i_mem_reg_write,
                              i_wb_rd, i_wb_reg_write);

endmodule

/* rtl/rv32i_pkg.sv */
// Shared types for the RV32I pipeline
// Vector typedefs, control enums, pipeline register structs

`include "rv32i_cfg.svh"

package rv32i_pkg;

    // Sizes derived from the config header
    localparam int REG_COUNT  = `RV_REG_COUNT;
    localparam int DMEM_WORDS = `RV_DMEM_WORDS;
    localparam int DMEM_AW    = $clog2(`RV_DMEM_WORDS);

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;

    // ==============================
    // Enums
    // ==============================
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // Write-back source
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_e;

    // Operand source for execute
    typedef enum logic [1:0] {FWD_REG, FWD_WB, FWD_MEM} fwd_sel_e;

    // ==============================
    // Control bundle and pipe regs
    // ==============================
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        wb_sel_e wb_sel;
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    branch;
        // BNE when set, BEQ otherwise
        logic    branch_ne;
        logic    jal;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        word_t     pc4;
        word_t     imm;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        wb_sel_e   wb_sel;
    } ex_mem_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     load_data;
        word_t     pc4;
        word_t     imm;
        reg_addr_t rd;
        logic      reg_write;
        wb_sel_e   wb_sel;
    } mem_wb_t;

endpackage

/* rtl/rv32i_regfile.sv */
// Register file, two read ports and one write port
// x0 reads zero, same-cycle writes pass through

`timescale 1ns/100ps

module rv32i_regfile import rv32i_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  word_t     i_wdata,
    input  reg_addr_t i_raddr1,
    input  reg_addr_t i_raddr2,
    output word_t     o_rdata1,
    output word_t     o_rdata2
);

    word_t regs [REG_COUNT];
    logic  wr_live;

    // Write that actually lands this edge
    assign wr_live = i_we && i_waddr != '0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Write-through so decode sees the retiring value
    assign o_rdata1 = (wr_live && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
    assign o_rdata2 = (wr_live && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

/* rv32i_pipe.f */
+incdir+include
rtl/rv32i_pkg.sv
rtl/rv32i_decoder.sv
rtl/rv32i_regfile.sv
rtl/rv32i_hazard_unit.sv
rtl/rv32i_execute.sv
rtl/rv32i_data_mem.sv
rtl/rv32i_core.sv
sim/rv32i_assertions.sv
sim/rv32i_tb.sv

/* sim/rv32i_assertions.sv */
// Concurrent checks bound into the core
// Strobe rules around reset, flush priority over stall

`timescale 1ns/100ps

module rv32i_assertions import rv32i_pkg::*; (
    input logic      i_clk,
    input logic      i_reset,
    input logic      i_wb_valid,
    input reg_addr_t i_wb_rd,
    input logic      i_stall,
    input logic      i_flush,
    input word_t     i_pc,
    input word_t     i_target
);

    // Failure tally
    int fail_count = 0;

    // ==============================
    // Write-back strobe
    // ==============================
    // x0 destinations never strobe
    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_valid |-> i_wb_rd != '0)
    else begin
        fail_count++;
        $error("write-back strobe raised with rd equal to x0");
    end

    // Pipeline is all bubbles right after reset
    quiet_after_reset: assert property (@(posedge i_clk)
        $fell(i_reset) |-> !i_wb_valid)
    else begin
        fail_count++;
        $error("write-back strobe in the first cycle after reset");
    end

    // ==============================
    // Stall versus flush
    // ==============================
    // PC takes the redirect target on a flush and holds on a lone stall
    flush_over_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_stall || i_flush) |=> i_pc == ($past(i_flush) ? $past(i_target) : $past(i_pc)))
    else begin
        fail_count++;
        $error("PC neither took the flush target nor held during a stall");
    end

endmodule

/* sim/rv32i_tb.sv */
// Directed testbench for the RV32I pipeline core
// Clock, reset, instruction ROM, test tasks, checks and timeout

`timescale 1ns/100ps

`include "rv32i_cfg.svh"

module rv32i_tb import rv32i_pkg::*; ();

    localparam int          RESET_CYCLES   = 4;
    localparam int          DRAIN_CYCLES   = 6;
    localparam int          ROM_WORDS      = 32;
    localparam word_t       NOP_INSN       = 32'h0000_0013;
    localparam logic [31:0] RAND_SEED      = 32'h69f3_7281;
    // Program lengths of the four tests
    localparam int          ALU_LEN        = 21;
    localparam int          MEM_LEN        = 9;
    localparam int          BRANCH_LEN     = 13;
    localparam int          JAL_LEN        = 10;
    localparam int          TIMEOUT_CYCLES = 4 * (ALU_LEN + MEM_LEN + BRANCH_LEN + JAL_LEN) + 100;

    localparam logic [6:0]  OP_IMM  = 7'b0010011;
    localparam logic [6:0]  OP_LOAD = 7'b0000011;
    localparam logic [6:0]  F7_BASE = 7'b0000000;
    // SUB and SRA
    localparam logic [6:0]  F7_ALT  = 7'b0100000;

    // One retired register write
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_rec_t;

    logic        clk;
    logic        reset;
    word_t       imem_addr;
    word_t       imem_data;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    word_t       wb_data;

    // Program ROM
    word_t       rom [ROM_WORDS];
    int          rom_len;
    logic [29:0] rom_idx;

    word_t       prog_q [$];
    wb_rec_t     exp_q [$];
    wb_rec_t     got_q [$];
    // Expected architectural register values
    word_t       xr [32];
    logic        collecting;
    int          error_count;
    int          timeout_count;
    int          cycle_count;

    rv32i_core u_rv32i_core (
        .i_clk       (clk),
        .i_reset     (reset),
        .o_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_wb_valid  (wb_valid),
        .o_wb_rd     (wb_rd),
        .o_wb_data   (wb_data)
    );

    bind rv32i_core rv32i_assertions u_assertions (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb_valid (o_wb_valid),
        .i_wb_rd    (o_wb_rd),
        .i_stall    (stall),
        .i_flush    (flush),
        .i_pc       (pc_q),
        .i_target   (target)
    );

    // Same-cycle fetch, NOP past the end of the program
    assign rom_idx   = imem_addr[31:2];
    assign imem_data = (rom_idx < rom_len) ? rom[rom_idx[4:0]] : NOP_INSN;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Strobe sampled on the rising edge
    always @(posedge clk) begin
        if (collecting && wb_valid === 1'b1) begin
            got_q.push_back({wb_rd, wb_data});
        end
    end

    // ==============================
    // Instruction encoders
    // ==============================
    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t store_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // Byte offset, bit 0 dropped by the format
    function automatic word_t branch_insn(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t lui_insn(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t jal_insn(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ==============================
    // Program building and checks
    // ==============================
    task automatic start_program();
        prog_q.delete();
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
    endtask

    // Instruction with no architectural write
    task automatic push_insn(word_t insn);
        prog_q.push_back(insn);
    endtask

    // Instruction plus the write it must retire
    task automatic push_write(word_t insn, reg_addr_t rd, word_t value);
        prog_q.push_back(insn);
        exp_q.push_back({rd, value});
        xr[rd] = value;
    endtask

    task automatic check_value(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic run_program(string name);
        int i;
        @(negedge clk);
        collecting = 1'b0;
        reset      = 1'b1;
        // ROM changes only while the core is held in reset
        rom_len = prog_q.size();
        for (i = 0; i < prog_q.size(); i++) begin
            rom[i] = prog_q[i];
        end
        got_q.delete();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_value({name, " o_imem_addr"}, imem_addr, `RV_RESET_PC);
        check_value({name, " o_wb_valid"}, word_t'(wb_valid), '0);
        collecting = 1'b1;
        while (got_q.size() < exp_q.size()) begin
            @(negedge clk);
        end
        // Drain so late stray strobes are caught
        repeat (DRAIN_CYCLES) @(negedge clk);
        collecting = 1'b0;
        if (got_q.size() != exp_q.size()) begin
            error_count++;
            $display("%s retired %0d register writes where %0d were expected",
                     name, got_q.size(), exp_q.size());
        end
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value($sformatf("o_wb_rd (%s, write %0d)", name, i),
                        word_t'(got_q[i].rd), word_t'(exp_q[i].rd));
            check_value($sformatf("o_wb_data (%s, write %0d)", name, i),
                        got_q[i].data, exp_q[i].data);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic alu_forwarding_test();
        logic [11:0] ia;
        logic [11:0] ib;
        // Negative x1 so right shifts show sign fill
        ia = {1'b1, 11'($urandom)};
        ib = 12'($urandom);
        start_program();
        push_write(i_type(ia, 0, 3'b000, 1, OP_IMM), 1, sext12(ia));
        push_write(i_type(ib, 0, 3'b000, 2, OP_IMM), 2, sext12(ib));
        // x2 from MEM, x1 from WB
        push_write(r_type(F7_BASE, 2, 1, 3'b000, 3), 3, xr[1] + xr[2]);
        push_write(r_type(F7_ALT, 1, 3, 3'b000, 4), 4, xr[3] - xr[1]);
        push_write(r_type(F7_BASE, 3, 4, 3'b111, 5), 5, xr[4] & xr[3]);
        push_write(r_type(F7_BASE, 2, 5, 3'b110, 6), 6, xr[5] | xr[2]);
        push_write(r_type(F7_BASE, 4, 6, 3'b100, 7), 7, xr[6] ^ xr[4]);
        push_write(r_type(F7_BASE, 1, 7, 3'b010, 8), 8,
                   {31'b0, $signed(xr[7]) < $signed(xr[1])});
        push_write(r_type(F7_BASE, 7, 1, 3'b011, 9), 9, {31'b0, xr[1] < xr[7]});
        push_write(r_type(F7_BASE, 2, 7, 3'b001, 10), 10, xr[7] << xr[2][4:0]);
        push_write(r_type(F7_BASE, 2, 1, 3'b101, 11), 11, xr[1] >> xr[2][4:0]);
        push_write(r_type(F7_ALT, 2, 1, 3'b101, 12), 12,
                   word_t'($signed(xr[1]) >>> xr[2][4:0]));
        // Immediate forms
        push_write(i_type(12'h5a5, 12, 3'b100, 13, OP_IMM), 13, xr[12] ^ sext12(12'h5a5));
        push_write(i_type(12'h7f0, 13, 3'b111, 14, OP_IMM), 14, xr[13] & sext12(12'h7f0));
        push_write(i_type(12'hff0, 14, 3'b110, 15, OP_IMM), 15, xr[14] | sext12(12'hff0));
        push_write(i_type(12'hfff, 15, 3'b010, 16, OP_IMM), 16,
                   {31'b0, $signed(xr[15]) < $signed(sext12(12'hfff))});
        push_write(i_type(12'h001, 16, 3'b011, 17, OP_IMM), 17, {31'b0, xr[16] < 32'd1});
        push_write(i_type(12'h007, 1, 3'b001, 18, OP_IMM), 18, xr[1] << 7);
        push_write(i_type(12'h009, 1, 3'b101, 19, OP_IMM), 19, xr[1] >> 9);
        push_write(i_type(12'h409, 1, 3'b101, 20, OP_IMM), 20, word_t'($signed(xr[1]) >>> 9));
        push_write(i_type(12'hffd, 20, 3'b000, 21, OP_IMM), 21, xr[20] + sext12(12'hffd));
        run_program("alu test");
    endtask

    task automatic load_use_test();
        logic [19:0] hi;
        logic [11:0] lo;
        hi = 20'($urandom);
        lo = 12'($urandom);
        start_program();
        push_write(lui_insn(hi, 1), 1, {hi, 12'b0});
        push_write(i_type(lo, 1, 3'b000, 1, OP_IMM), 1, xr[1] + sext12(lo));
        push_write(i_type(12'h040, 0, 3'b000, 2, OP_IMM), 2, 32'h40);
        push_insn(store_word(12'h008, 1, 2));
        // Load returns the stored word
        push_write(i_type(12'h008, 2, 3'b010, 3, OP_LOAD), 3, xr[1]);
        // Load-use, one stall
        push_write(r_type(F7_BASE, 1, 3, 3'b000, 4), 4, xr[3] + xr[1]);
        push_insn(store_word(12'h00c, 4, 2));
        push_write(i_type(12'h00c, 2, 3'b010, 5, OP_LOAD), 5, xr[4]);
        push_write(r_type(F7_ALT, 3, 5, 3'b000, 6), 6, xr[5] - xr[3]);
        run_program("load/store test");
    endtask

    task automatic branch_flush_test();
        start_program();
        push_write(i_type(12'd5, 0, 3'b000, 1, OP_IMM), 1, 32'd5);
        push_write(i_type(12'd5, 0, 3'b000, 2, OP_IMM), 2, 32'd5);
        // Taken BEQ, skips the next two
        push_insn(branch_insn(13'd12, 2, 1, 3'b000));
        push_insn(i_type(12'd1, 0, 3'b000, 3, OP_IMM));
        push_insn(i_type(12'd2, 0, 3'b000, 4, OP_IMM));
        // Not taken BNE
        push_insn(branch_insn(13'd12, 2, 1, 3'b001));
        push_write(i_type(12'd3, 0, 3'b000, 5, OP_IMM), 5, 32'd3);
        push_write(i_type(12'd7, 0, 3'b000, 6, OP_IMM), 6, 32'd7);
        // Taken BNE on forwarded operands
        push_insn(branch_insn(13'd12, 6, 5, 3'b001));
        push_insn(i_type(12'd9, 0, 3'b000, 7, OP_IMM));
        push_insn(i_type(12'd9, 0, 3'b000, 8, OP_IMM));
        // Not taken BEQ
        push_insn(branch_insn(13'd8, 6, 5, 3'b000));
        push_write(i_type(12'd11, 0, 3'b000, 9, OP_IMM), 9, 32'd11);
        run_program("branch test");
    endtask

    task automatic jal_lui_test();
        logic [19:0] hi;
        logic [19:0] hi2;
        hi  = 20'($urandom);
        hi2 = 20'($urandom);
        start_program();
        push_write(lui_insn(hi, 1), 1, {hi, 12'b0});
        // JAL at PC 4 links PC+4
        push_write(jal_insn(21'd12, 2), 2, 32'd4 + 32'd4);
        push_insn(i_type(12'd1, 0, 3'b000, 3, OP_IMM));
        push_insn(i_type(12'd2, 0, 3'b000, 4, OP_IMM));
        // Write to x0, no strobe
        push_insn(i_type(12'd123, 0, 3'b000, 0, OP_IMM));
        push_write(r_type(F7_BASE, 1, 0, 3'b000, 5), 5, xr[0] + xr[1]);
        // JAL without link
        push_insn(jal_insn(21'd8, 0));
        push_insn(i_type(12'd1, 0, 3'b000, 7, OP_IMM));
        push_write(i_type(12'd1, 2, 3'b000, 8, OP_IMM), 8, xr[2] + 32'd1);
        push_write(lui_insn(hi2, 10), 10, {hi2, 12'b0});
        run_program("jal/lui test");
    endtask

    // ==============================
    // Result
    // ==============================
    task automatic report_result();
        int assert_fails;
        assert_fails = u_rv32i_core.u_assertions.fail_count;
        $display("Errors: %0d, assertion failures: %0d, timeouts: %0d",
                 error_count, assert_fails, timeout_count);
        if (error_count == 0 && assert_fails == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
    endtask

    initial begin
        reset         = 1'b1;
        rom_len       = 0;
        collecting    = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        void'($urandom(RAND_SEED));
        alu_forwarding_test();
        load_use_test();
        branch_flush_test();
        jal_lui_test();
        report_result();
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timeout_count = 1;
        $display("Timeout after %0d cycles, the expected register writes never arrived",
                 cycle_count);
        report_result();
        $finish;
    end

endmodule
